// File: board_sweep.sv
`default_nettype none

module board_sweep (
  input  wire logic               CLOCK_50,
  input  wire logic               rst_n,
  input  wire logic               step,
  output screen_pkg::board_pos_t  sweep_pos,
  output logic                    sweep_last
);

  import screen_pkg::*;

  localparam logic [x_w-1:0] x_last = x_w'(board_w - 1);
  localparam logic [y_w-1:0] y_last = y_w'(board_h - 1);

  board_pos_t pos;
  board_pos_t pos_next;

  assign sweep_last = (pos.xy.x == x_last) && (pos.xy.y == y_last);
  assign sweep_pos  = pos;

  // y is the fast index, x moves on when a column is done
  always_comb
  begin
    pos_next = pos;
    if (sweep_last)
    begin
      pos_next.flat = '0;                    // Back to the corner for the next sweep
    end
    else if (pos.xy.y == y_last)
    begin
      pos_next.xy.y = '0;
      pos_next.xy.x = pos.xy.x + 1'b1;
    end
    else
    begin
      pos_next.xy.y = pos.xy.y + 1'b1;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      pos.flat <= '0;
    else if (step)
      pos <= pos_next;
  end

endmodule

`default_nettype wire

// File: game_control.sv
`default_nettype none

module game_control (
  input  wire logic           CLOCK_50,
  input  wire logic           rst_n,
  input  wire logic           start,
  input  wire logic           req_ready,
  input  wire logic           sweep_last,
  input  wire logic           running,
  output game_pkg::phase_t    phase,
  output logic                req_valid,
  output logic                step,
  output logic                game_active,
  output logic                game_over
);

  import game_pkg::*;

  phase_t phase_next;
  logic   accept;
  logic   sweeping;

  assign req_valid = (phase != idle) && (phase != done);
  assign accept    = req_valid && req_ready;

  assign sweeping  = (phase == clear) || (phase == fill);
  assign step      = accept && sweeping;        // Sweep moves only on an accepted pixel

  assign game_active = (phase == draw_p1) || (phase == draw_p2) || (phase == draw_p3) ||
                       (phase == draw_p4) || (phase == draw_timer);

  assign game_over = (phase == done);

  always_comb
  begin
    phase_next = phase;
    case (phase)
      idle:
      begin
        if (start)
          phase_next = clear;
      end
      clear:
      begin
        if (accept && sweep_last)
          phase_next = draw_p1;
      end
      draw_p1:
      begin
        if (accept)
          phase_next = draw_p2;
      end
      draw_p2:
      begin
        if (accept)
          phase_next = draw_p3;
      end
      draw_p3:
      begin
        if (accept)
          phase_next = draw_p4;
      end
      draw_p4:
      begin
        if (accept)
          phase_next = draw_timer;
      end
      draw_timer:
      begin
        // Round ends once the timer has stopped
        if (accept)
          phase_next = running ? draw_p1 : fill;
      end
      fill:
      begin
        if (accept && sweep_last)
          phase_next = done;
      end
      done:       phase_next = done;       // Final until reset
      default:    phase_next = idle;
    endcase
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      phase <= idle;
    else
      phase <= phase_next;
  end

endmodule

`default_nettype wire

// File: game_pkg.sv
`default_nettype none

package game_pkg;

  // Sequencer phases, in the order a round walks through them
  typedef enum logic [3:0] {
    idle       = 4'd0,
    clear      = 4'd1,
    draw_p1    = 4'd2,
    draw_p2    = 4'd3,
    draw_p3    = 4'd4,
    draw_p4    = 4'd5,
    draw_timer = 4'd6,
    fill       = 4'd7,
    done       = 4'd8
  } phase_t;

  // Timer pixels run along the bottom row
  localparam logic [screen_pkg::y_w-1:0] timer_row = 7'd119;

  // A tick at or past this x ends the round
  localparam logic [screen_pkg::x_w-1:0] timer_end = 8'd158;

endpackage

`default_nettype wire

// File: pixel_writer.sv
`default_nettype none

module pixel_writer (
  input  wire logic                   CLOCK_50,
  input  wire logic                   rst_n,
  input  wire game_pkg::phase_t       phase,
  input  wire logic                   req_valid,
  input  wire screen_pkg::board_pos_t sweep_pos,
  input  wire logic [screen_pkg::x_w-1:0] timer_x,
  input  wire screen_pkg::player_pos_t players,
  output logic                        req_ready,
  output screen_pkg::pixel_t          pix,
  output logic                        pix_valid,
  input  wire logic                   pix_ready
);

  import screen_pkg::*;
  import game_pkg::*;

  pixel_t     pix_next;
  logic [1:0] player_idx;
  logic       load;

  assign req_ready = !pix_valid || pix_ready;   // Empty, or draining this cycle
  assign load      = req_valid && req_ready;

  always_comb
  begin
    case (phase)
      draw_p2: player_idx = 2'd1;
      draw_p3: player_idx = 2'd2;
      draw_p4: player_idx = 2'd3;
      default: player_idx = 2'd0;
    endcase
  end

  always_comb
  begin
    pix_next.pos    = sweep_pos;
    pix_next.colour = colour_black;            // Clear phase
    case (phase)
      fill:
        pix_next.colour = colour_white;
      draw_p1, draw_p2, draw_p3, draw_p4:
      begin
        pix_next.pos    = players[player_idx];
        pix_next.colour = player_colour[player_idx];
      end
      draw_timer:
      begin
        pix_next.pos.xy.x = timer_x;
        pix_next.pos.xy.y = timer_row;
        pix_next.colour   = colour_white;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      pix_valid <= 1'b0;
    else if (load)
      pix_valid <= 1'b1;
    else if (pix_ready)
      pix_valid <= 1'b0;                      // Drained with nothing behind it
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (load)
      pix <= pix_next;
  end

endmodule

`default_nettype wire

// File: round_timer.sv
`default_nettype none

module round_timer (
  input  wire logic                        CLOCK_50,
  input  wire logic                        rst_n,
  input  wire logic                        game_tick,
  input  wire logic                        game_active,
  output logic [screen_pkg::x_w-1:0]       timer_x,
  output logic                             running
);

  import game_pkg::*;

  logic tick_live;

  assign tick_live = game_tick && game_active;   // Ticks outside the loop are ignored

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      timer_x <= '0;
      running <= 1'b1;
    end
    else if (tick_live)
    begin
      timer_x <= timer_x + 1'b1;
      // Sticky until the next reset
      if (timer_x >= timer_end)
        running <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from the simulation log
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert --top-module turf_wars_tb -f turf_wars.f \
  -o turf_wars_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/turf_wars_sim > sim.log 2>&1 ; cat sim.log
grep -q "^Simulation completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: screen_pkg.sv
`default_nettype none

package screen_pkg;

  localparam int board_w = 160;
  localparam int board_h = 120;

  localparam int x_w = 8;
  localparam int y_w = 7;

  typedef logic [2:0] colour_t;              // One bit each for blue, green, red

  localparam colour_t colour_black = 3'b000;
  localparam colour_t colour_white = 3'b111;

  // Index 0 is player 1
  localparam colour_t [3:0] player_colour = {3'b110, 3'b100, 3'b010, 3'b001};

  typedef struct packed {
    logic [x_w-1:0] x;                       // Upper bits of the board word
    logic [y_w-1:0] y;
  } board_xy_t;

  // Same word seen as a plain count or as a coordinate pair
  typedef union packed {
    logic [x_w+y_w-1:0] flat;
    board_xy_t          xy;
  } board_pos_t;

  typedef struct packed {
    board_pos_t pos;
    colour_t    colour;
  } pixel_t;

  typedef board_pos_t [3:0] player_pos_t;    // Entry 0 is player 1

endpackage

`default_nettype wire

// File: turf_wars.f
screen_pkg.sv
game_pkg.sv
board_sweep.sv
round_timer.sv
game_control.sv
pixel_writer.sv
turf_wars_top.sv
turf_wars_sva.sv
turf_wars_tb.sv

// File: turf_wars_sva.sv
`default_nettype none

module turf_wars_sva (
  input  wire logic               CLOCK_50,
  input  wire logic               rst_n,
  input  wire screen_pkg::pixel_t pix,
  input  wire logic               pix_valid,
  input  wire logic               pix_ready,
  input  wire logic               game_over
);

  import screen_pkg::*;

  int unsigned fail_count = 0;

  // Stalled pixel stays put until the sink takes it
  stall_holds: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix))
  else
  begin
    $error("pix changed or vanished during a stall");
    fail_count = fail_count + 1;
  end

  // Once the round is over only the held last pixel may leave
  quiet_after_end: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    game_over && !(pix_valid && !pix_ready) |=> !pix_valid)
  else
  begin
    $error("pix_valid raised after game_over");
    fail_count = fail_count + 1;
  end

  on_board: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    pix_valid |-> (pix.pos.xy.x < x_w'(board_w)) && (pix.pos.xy.y < y_w'(board_h)))
  else
  begin
    $error("pixel off the board");
    fail_count = fail_count + 1;
  end

endmodule

`default_nettype wire

// File: turf_wars_tb.sv
`default_nettype none

module turf_wars_tb;

  import screen_pkg::*;
  import game_pkg::*;

  typedef enum int {on_clear, on_loop, on_fill, finished} stage_t;

  logic           CLOCK_50     = 1'b0;
  logic           rst_n        = 1'b0;
  logic           start        = 1'b0;
  logic           game_tick    = 1'b0;
  logic           pix_ready    = 1'b0;
  player_pos_t    players      = '0;
  pixel_t         pix;
  logic           pix_valid;
  logic           game_over;

  integer         seed         = 32'hfb53;
  int             tick_wait    = 40;      // Cycles to the next game_tick
  int             errors       = 0;
  stage_t         stage        = on_clear;
  int             count        = 0;       // Transfers seen in the current stage
  logic [x_w-1:0] last_timer_x = '0;

  turf_wars_top i_turf_wars_top (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .start     (start),
    .game_tick (game_tick),
    .players   (players),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .game_over (game_over)
  );

  bind turf_wars_top turf_wars_sva i_turf_wars_sva (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .game_over (game_over)
  );

  always #2 CLOCK_50 = ~CLOCK_50;

  // Sink about 70% ready, ticks far enough apart that one group fits between them
  always @(posedge CLOCK_50)
  begin
    pix_ready <= ($unsigned($random(seed)) % 10) < 7;
    if (tick_wait == 0)
    begin
      game_tick <= 1'b1;
      tick_wait <= 40 + int'($unsigned($random(seed)) % 16);
    end
    else
    begin
      game_tick <= 1'b0;
      tick_wait <= tick_wait - 1;
    end
  end

  // Stage index and transfer count give the pixel the sink should see
  function automatic pixel_t expected_pixel(input stage_t at, input int n);
    pixel_t     p;
    logic [1:0] who;
    p            = '0;
    who          = 2'(n % 5);
    p.pos.xy.x   = x_w'(n / board_h);        // Column-major sweep
    p.pos.xy.y   = y_w'(n % board_h);
    p.colour     = (at == on_fill) ? colour_white : colour_black;
    if (at == on_loop)
    begin
      if (n % 5 < 4)
      begin
        p.pos    = players[who];
        p.colour = player_colour[who];
      end
      else
      begin
        p.pos.xy.x = '0;                     // Timer x is checked on its own
        p.pos.xy.y = y_w'(board_h - 1);
        p.colour   = colour_white;
      end
    end
    return p;
  endfunction

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input int n);
    if (got !== exp)
    begin
      $display("[ERROR] pix: got %h expected %h (stage %0d, transfer %0d)", got, exp, stage, n);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic take_pixel(input pixel_t got);
    pixel_t exp;
    if (stage == on_loop && count > 0 && count % 5 == 0 && got.colour == colour_white)
    begin
      // Fill has begun, so the timer must have run past its end
      if (last_timer_x != timer_end + 8'd1)
      begin
        $display("[ERROR] timer_x at end of round: got %h expected %h",
                 last_timer_x, timer_end + 8'd1);
        errors++;
      end
      stage = on_fill;
      count = 0;
    end
    if (stage == finished)
    begin
      $display("A pixel was transferred after the end of the round");
      errors++;
    end
    else
    begin
      exp = expected_pixel(stage, count);
      if (stage == on_loop && count % 5 == 4)
      begin
        if (got.pos.xy.x < last_timer_x || got.pos.xy.x > x_w'(board_w - 1))
        begin
          $display("[ERROR] timer_x: got %h after %h", got.pos.xy.x, last_timer_x);
          errors++;
        end
        exp.pos.xy.x = got.pos.xy.x;
        last_timer_x = got.pos.xy.x;
      end
      check_pixel(got, exp, count);
      if (stage == on_fill && count == board_w * board_h - 1)
      begin
        check_flag("game_over", game_over, 1'b1);   // Last pixel still held
        stage = finished;
      end
      else
      begin
        check_flag("game_over", game_over, 1'b0);
        if (stage == on_clear && count == board_w * board_h - 1)
        begin
          stage = on_loop;
          count = 0;
        end
        else
          count++;
      end
    end
  endtask

  // Comparison process, one call per transfer
  always @(posedge CLOCK_50)
  begin
    if (rst_n && pix_valid && pix_ready)
      take_pixel(pix);
  end

  initial
  begin
    int   waited;
    logic timed_out;
    timed_out = 1'b0;
    repeat (10) @(posedge CLOCK_50);
    rst_n <= 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      players[i].xy.x <= x_w'($unsigned($random(seed)) % board_w);
      players[i].xy.y <= y_w'($unsigned($random(seed)) % board_h);
    end
    repeat (20)
    begin
      @(posedge CLOCK_50);
      check_flag("pix_valid", pix_valid, 1'b0);
      check_flag("game_over", game_over, 1'b0);
    end
    start <= 1'b1;
    @(posedge CLOCK_50);
    start <= 1'b0;
    waited = 0;
    while (stage != finished && waited < 250000)
    begin
      @(posedge CLOCK_50);
      waited++;
    end
    if (stage != finished)
    begin
      $display("Timed out waiting for the fill sweep to finish");
      timed_out = 1'b1;
    end
    else
    begin
      waited = 0;
      while (!game_over && waited < 10)
      begin
        @(posedge CLOCK_50);
        waited++;
      end
      repeat (40) @(posedge CLOCK_50);      // Any stray transfer shows up here
      check_flag("game_over", game_over, 1'b1);
      check_flag("pix_valid", pix_valid, 1'b0);
    end
    $display("Check errors: %0d, assertion failures: %0d",
             errors, i_turf_wars_top.i_turf_wars_sva.fail_count);
    if (errors == 0 && i_turf_wars_top.i_turf_wars_sva.fail_count == 0 && !timed_out)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: turf_wars_top.sv
`default_nettype none

module turf_wars_top (
  input  wire logic                CLOCK_50,
  input  wire logic                rst_n,
  input  wire logic                start,
  input  wire logic                game_tick,
  input  wire screen_pkg::player_pos_t players,
  output screen_pkg::pixel_t       pix,
  output logic                     pix_valid,
  input  wire logic                pix_ready,
  output logic                     game_over
);

  import screen_pkg::*;
  import game_pkg::*;

  phase_t         phase;
  logic           req_valid;
  logic           req_ready;
  logic           step;
  logic           game_active;
  board_pos_t     sweep_pos;
  logic           sweep_last;
  logic [x_w-1:0] timer_x;
  logic           running;

  game_control i_game_control (
    .CLOCK_50    (CLOCK_50),
    .rst_n       (rst_n),
    .start       (start),
    .req_ready   (req_ready),
    .sweep_last  (sweep_last),
    .running     (running),
    .phase       (phase),
    .req_valid   (req_valid),
    .step        (step),
    .game_active (game_active),
    .game_over   (game_over)
  );

  board_sweep i_board_sweep (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .step       (step),
    .sweep_pos  (sweep_pos),
    .sweep_last (sweep_last)
  );

  round_timer i_round_timer (
    .CLOCK_50    (CLOCK_50),
    .rst_n       (rst_n),
    .game_tick   (game_tick),
    .game_active (game_active),
    .timer_x     (timer_x),
    .running     (running)
  );

  // Output stage holds one pixel for the sink
  pixel_writer i_pixel_writer (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .phase     (phase),
    .req_valid (req_valid),
    .sweep_pos (sweep_pos),
    .timer_x   (timer_x),
    .players   (players),
    .req_ready (req_ready),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready)
  );

endmodule

`default_nettype wire
